/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int word_width = 32;
    localparam logic [word_width-1:0] reset_pc = 32'h8000_0000;

    // Primary opcodes that matter to static prediction
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_regimm  = 6'h01,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_blez    = 6'h06,
        op_bgtz    = 6'h07
    } opcode_e;

    localparam int opcode_msb = 31;
    localparam int opcode_lsb = 26;
    localparam int imm_msb    = 15;
    localparam int imm_lsb    = 0;
    localparam int index_msb  = 25;
    localparam int index_lsb  = 0;

    // REGIMM keeps its branch kind in the rt field
    localparam int rt_msb = 20;
    localparam int rt_lsb = 16;
    localparam logic [4:0] rt_bltz = 5'b00000;
    localparam logic [4:0] rt_bgez = 5'b00001;

endpackage

`default_nettype wire

/* source/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // Cache geometry, a line holds four instruction words
    localparam int line_words  = 4;
    localparam int line_count  = 64;
    localparam int offset_bits = $clog2(line_words);
    localparam int index_bits  = $clog2(line_count);
    localparam int tag_bits    = isa_pkg::word_width - index_bits - offset_bits - 2;

    // Redirect request from execute
    typedef struct packed {
        logic                             en;
        logic [isa_pkg::word_width-1:0] pc;
    } redirect_t;

    typedef enum logic [1:0] {
        refill_idle,
        refill_request,
        refill_fill
    } refill_state_e;

endpackage

`default_nettype wire

/* source/fetch_cache_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface fetch_cache_if;
    import isa_pkg::*;

    logic [word_width-1:0] pc;
    logic                  hit;
    // Words at pc and pc+4, only meaningful while hit is high
    logic [word_width-1:0] inst0;
    logic [word_width-1:0] inst1;

    modport fetch (
        output pc,
        input  hit, inst0, inst1
    );

    modport cache (
        input  pc,
        output hit, inst0, inst1
    );

endinterface

`default_nettype wire

/* source/branch_predictor.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_predictor (
    input  wire logic [isa_pkg::word_width-1:0] pc,
    input  wire logic [isa_pkg::word_width-1:0] inst,
    output logic                                pred_taken,
    output logic [isa_pkg::word_width-1:0]      pred_target
);
    import isa_pkg::*;

    opcode_e               opcode;
    logic [4:0]            regimm_rt;
    logic [word_width-1:0] pc_plus4;
    logic [word_width-1:0] jump_target;
    logic [word_width-1:0] branch_target;
    logic                  backward;

    assign opcode    = opcode_e'(inst[opcode_msb:opcode_lsb]);
    assign regimm_rt = inst[rt_msb:rt_lsb];
    assign pc_plus4  = pc + 32'd4;
    assign backward  = inst[imm_msb];

    // Jump keeps the region bits of the delay slot address
    assign jump_target = {pc_plus4[word_width-1:index_msb+3], inst[index_msb:index_lsb], 2'b00};
    assign branch_target = pc_plus4 +
        {{(word_width-imm_msb-3){inst[imm_msb]}}, inst[imm_msb:imm_lsb], 2'b00};

    always_comb begin
        pred_taken  = 1'b0;
        pred_target = '0;
        case (opcode)
            op_j, op_jal: begin
                pred_taken  = 1'b1;
                pred_target = jump_target;
            end
            op_beq, op_bne, op_blez, op_bgtz: begin
                pred_taken  = backward;
                pred_target = backward ? branch_target : '0;
            end
            op_regimm: begin
                if (regimm_rt == rt_bltz || regimm_rt == rt_bgez) begin
                    pred_taken  = backward;
                    pred_target = backward ? branch_target : '0;
                end
            end
            // Register jumps have no target known at fetch
            op_special: pred_taken = 1'b0;
            default:    pred_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* source/icache.sv */
`timescale 1ns/100ps
`default_nettype none

module icache (
    input  wire logic                           clk,
    input  wire logic                           rst,
    fetch_cache_if.cache                        cache,
    output logic                                mem_req,
    output logic [isa_pkg::word_width-1:0]      mem_addr,
    input  wire logic                           mem_valid,
    input  wire logic [isa_pkg::word_width-1:0] mem_data
);
    import isa_pkg::*;
    import fetch_pkg::*;

    logic [word_width-1:0] data_mem [line_count][line_words];
    logic [tag_bits-1:0]   tag_mem [line_count];
    logic [line_count-1:0] valid_bits;

    logic [offset_bits-1:0] lookup_offset;
    logic [offset_bits-1:0] next_offset;
    logic [index_bits-1:0]  lookup_index;
    logic [tag_bits-1:0]    lookup_tag;

    refill_state_e          state;
    logic [offset_bits-1:0] fill_word;
    logic [index_bits-1:0]  fill_index;
    logic [tag_bits-1:0]    fill_tag;
    logic                   fill_last;

    assign lookup_offset = cache.pc[offset_bits+1:2];
    assign lookup_index  = cache.pc[index_bits+offset_bits+1:offset_bits+2];
    assign lookup_tag    = cache.pc[word_width-1:word_width-tag_bits];

    // Wraps inside the line at the last offset, fetch ignores that word
    assign next_offset = lookup_offset + 1'b1;

    assign cache.hit   = valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign cache.inst0 = data_mem[lookup_index][lookup_offset];
    assign cache.inst1 = data_mem[lookup_index][next_offset];

    assign fill_last = (fill_word == offset_bits'(line_words - 1));
    assign mem_req   = (state == refill_request);
    assign mem_addr  = {fill_tag, fill_index, {(offset_bits+2){1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= refill_idle;
            valid_bits <= '0;
            fill_word  <= '0;
        end else begin
            case (state)
                refill_idle: begin
                    if (!cache.hit) begin
                        state <= refill_request;
                    end
                end
                refill_request: begin
                    // The old line is gone once its words start to be replaced
                    valid_bits[fill_index] <= 1'b0;
                    fill_word              <= '0;
                    state                  <= refill_fill;
                end
                refill_fill: begin
                    if (mem_valid) begin
                        fill_word <= fill_word + 1'b1;
                        if (fill_last) begin
                            valid_bits[fill_index] <= 1'b1;
                            state                  <= refill_idle;
                        end
                    end
                end
                default: state <= refill_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == refill_idle && !cache.hit) begin
            fill_index <= lookup_index;
            fill_tag   <= lookup_tag;
        end
        if (state == refill_fill && mem_valid) begin
            data_mem[fill_index][fill_word] <= mem_data;
            if (fill_last) begin
                tag_mem[fill_index] <= fill_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  wire logic                           clk,
    input  wire logic                           rst,
    fetch_cache_if.fetch                        cache,
    input  wire fetch_pkg::redirect_t           redirect,
    input  wire logic                           stall,
    input  wire logic                           pred_taken0,
    input  wire logic                           pred_taken1,
    input  wire logic [isa_pkg::word_width-1:0] pred_target0,
    input  wire logic [isa_pkg::word_width-1:0] pred_target1,
    output logic                                bundle_valid,
    output logic [1:0]                          bundle_count,
    output logic [isa_pkg::word_width-1:0]      bundle_pc,
    output logic [1:0][isa_pkg::word_width-1:0] bundle_inst,
    output logic [1:0]                          bundle_pred_taken,
    output logic [1:0][isa_pkg::word_width-1:0] bundle_pred_target,
    output logic                                fetch_stall
);
    import isa_pkg::*;
    import fetch_pkg::*;

    logic [word_width-1:0] pc;
    logic [word_width-1:0] pc_next;
    logic                  delay_flag;
    logic                  delay_flag_next;
    logic [word_width-1:0] delay_target;
    logic [word_width-1:0] delay_target_next;
    redirect_t             held_redirect;
    redirect_t             active_redirect;
    logic                  advance;
    logic                  last_in_line;
    logic [1:0]            issue_count;

    assign advance         = cache.hit && !stall;
    assign active_redirect = redirect.en ? redirect : held_redirect;
    assign last_in_line    = (pc[offset_bits+1:2] == offset_bits'(line_words - 1));

    assign cache.pc     = pc;
    assign fetch_stall  = !cache.hit;
    assign bundle_valid = cache.hit && !active_redirect.en;
    assign bundle_pc    = pc;
    assign bundle_count = issue_count;

    always_comb begin
        pc_next           = pc + 32'd8;
        delay_flag_next   = 1'b0;
        delay_target_next = delay_target;
        issue_count       = 2'd2;
        if (active_redirect.en) begin
            pc_next     = active_redirect.pc;
            issue_count = 2'd0;
        end else if (delay_flag) begin
            // Delay slot goes out alone, then the branch is followed
            pc_next     = delay_target;
            issue_count = 2'd1;
        end else if (last_in_line) begin
            pc_next     = pc + 32'd4;
            issue_count = 2'd1;
            if (pred_taken0) begin
                delay_flag_next   = 1'b1;
                delay_target_next = pred_target0;
            end
        end else if (pred_taken1) begin
            delay_flag_next   = 1'b1;
            delay_target_next = pred_target1;
        end else if (pred_taken0) begin
            pc_next = pred_target0;
        end
    end

    always_comb begin
        bundle_inst        = '0;
        bundle_pred_taken  = '0;
        bundle_pred_target = '0;
        if (issue_count != 2'd0) begin
            bundle_inst[0]        = cache.inst0;
            bundle_pred_taken[0]  = pred_taken0;
            bundle_pred_target[0] = pred_target0;
        end
        if (issue_count == 2'd2) begin
            bundle_inst[1]        = cache.inst1;
            bundle_pred_taken[1]  = pred_taken1;
            bundle_pred_target[1] = pred_target1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc            <= reset_pc;
            delay_flag    <= 1'b0;
            held_redirect <= '0;
        end else if (advance) begin
            pc            <= pc_next;
            delay_flag    <= delay_flag_next;
            held_redirect <= '0;
        end else if (redirect.en) begin
            // Kept until fetch can move, a newer one replaces it
            held_redirect <= redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            delay_target <= delay_target_next;
        end
    end

endmodule

`default_nettype wire

/* source/fetch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           redirect_valid,
    input  wire logic [isa_pkg::word_width-1:0] redirect_pc,
    input  wire logic                           stall,
    output logic                                bundle_valid,
    output logic [1:0]                          bundle_count,
    output logic [isa_pkg::word_width-1:0]      bundle_pc,
    output logic [1:0][isa_pkg::word_width-1:0] bundle_inst,
    output logic [1:0]                          bundle_pred_taken,
    output logic [1:0][isa_pkg::word_width-1:0] bundle_pred_target,
    output logic                                fetch_stall,
    output logic                                mem_req,
    output logic [isa_pkg::word_width-1:0]      mem_addr,
    input  wire logic                           mem_valid,
    input  wire logic [isa_pkg::word_width-1:0] mem_data
);
    import isa_pkg::*;
    import fetch_pkg::*;

    fetch_cache_if fetch_bus ();

    redirect_t             redirect;
    logic [word_width-1:0] pc_plus4;
    logic                  pred_taken0;
    logic                  pred_taken1;
    logic [word_width-1:0] pred_target0;
    logic [word_width-1:0] pred_target1;

    assign redirect = '{en: redirect_valid, pc: redirect_pc};
    assign pc_plus4 = fetch_bus.pc + 32'd4;

    branch_predictor predictor0 (
        .pc          (fetch_bus.pc),
        .inst        (fetch_bus.inst0),
        .pred_taken  (pred_taken0),
        .pred_target (pred_target0)
    );

    branch_predictor predictor1 (
        .pc          (pc_plus4),
        .inst        (fetch_bus.inst1),
        .pred_taken  (pred_taken1),
        .pred_target (pred_target1)
    );

    fetch_unit fetch_unit_i (
        .clk                (clk),
        .rst                (rst),
        .cache              (fetch_bus.fetch),
        .redirect           (redirect),
        .stall              (stall),
        .pred_taken0        (pred_taken0),
        .pred_taken1        (pred_taken1),
        .pred_target0       (pred_target0),
        .pred_target1       (pred_target1),
        .bundle_valid       (bundle_valid),
        .bundle_count       (bundle_count),
        .bundle_pc          (bundle_pc),
        .bundle_inst        (bundle_inst),
        .bundle_pred_taken  (bundle_pred_taken),
        .bundle_pred_target (bundle_pred_target),
        .fetch_stall        (fetch_stall)
    );

    icache icache_i (
        .clk       (clk),
        .rst       (rst),
        .cache     (fetch_bus.cache),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_data  (mem_data)
    );

endmodule

`default_nettype wire

/* verif/imem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module imem_model (
    input  wire logic        clk,
    input  wire logic        mem_req,
    input  wire logic [31:0] mem_addr,
    output logic             mem_valid,
    output logic [31:0]      mem_data
);

    // Branch table on top of a filler ALU word made from the address
    function automatic logic [31:0] program_word(input logic [31:0] addr);
        case (addr)
            32'h8000_0008: program_word = {6'h02, 26'h000_0011};
            32'h8000_004c: program_word = {6'h02, 26'h000_0020};
            32'h8000_0084: program_word = {6'h05, 5'd1, 5'd2, 16'h0004};
            32'h8000_0094: program_word = {6'h04, 5'd3, 5'd0, 16'hfffe};
            default:       program_word = {6'h09, 5'd0, 5'd1, addr[15:0] ^ addr[31:16]};
        endcase
    endfunction

    initial begin : responder
        logic [31:0] line_addr;
        int          gap;
        mem_valid = 1'b0;
        mem_data  = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                line_addr = mem_addr;
                // Four words in ascending order, each after its own random gap
                for (int word = 0; word < 4; word++) begin
                    gap = $urandom_range(6, 1);
                    repeat (gap) @(posedge clk);
                    #2;
                    mem_valid = 1'b1;
                    mem_data  = program_word(line_addr + 32'(4 * word));
                    @(posedge clk);
                    #2;
                    mem_valid = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/fetch_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;
    import isa_pkg::*;

    logic                       clk;
    logic                       rst;
    logic                       redirect_valid;
    logic [word_width-1:0]      redirect_pc;
    logic                       stall;
    logic                       bundle_valid;
    logic [1:0]                 bundle_count;
    logic [word_width-1:0]      bundle_pc;
    logic [1:0][word_width-1:0] bundle_inst;
    logic [1:0]                 bundle_pred_taken;
    logic [1:0][word_width-1:0] bundle_pred_target;
    logic                       fetch_stall;
    logic                       mem_req;
    logic [word_width-1:0]      mem_addr;
    logic                       mem_valid;
    logic [word_width-1:0]      mem_data;

    // Reference model of the next-pc rules
    logic [word_width-1:0] ref_pc;
    logic                  ref_delay;
    logic [word_width-1:0] ref_target;
    logic                  exp_single;
    logic [word_width-1:0] exp_inst0;
    logic [word_width-1:0] exp_inst1;
    logic [32:0]           exp_pred0;
    logic [32:0]           exp_pred1;
    logic                  accepted;
    logic                  hold_stall;
    logic                  left_loop;
    int                    refill_left;
    logic                  last_word_seen;
    int                    loop_passes;
    int                    tail_hits;
    int                    entry_hits;
    int                    bundles;
    int                    errors = 0;
    bit                    run_ok;

    fetch_top dut_i (
        .clk                (clk),
        .rst                (rst),
        .redirect_valid     (redirect_valid),
        .redirect_pc        (redirect_pc),
        .stall              (stall),
        .bundle_valid       (bundle_valid),
        .bundle_count       (bundle_count),
        .bundle_pc          (bundle_pc),
        .bundle_inst        (bundle_inst),
        .bundle_pred_taken  (bundle_pred_taken),
        .bundle_pred_target (bundle_pred_target),
        .fetch_stall        (fetch_stall),
        .mem_req            (mem_req),
        .mem_addr           (mem_addr),
        .mem_valid          (mem_valid),
        .mem_data           (mem_data)
    );

    imem_model memory_i (
        .clk       (clk),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_data  (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Program: j at 0x08 to 0x44, j at offset 3 (0x4c) to 0x80,
    // forward bne at 0x84, backward beq at 0x94 closing a loop on 0x90
    function automatic logic [31:0] program_word(input logic [31:0] addr);
        case (addr)
            32'h8000_0008: program_word = {6'h02, 26'h000_0011};
            32'h8000_004c: program_word = {6'h02, 26'h000_0020};
            32'h8000_0084: program_word = {6'h05, 5'd1, 5'd2, 16'h0004};
            32'h8000_0094: program_word = {6'h04, 5'd3, 5'd0, 16'hfffe};
            default:       program_word = {6'h09, 5'd0, 5'd1, addr[15:0] ^ addr[31:16]};
        endcase
    endfunction

    // Static rule, the top bit is the taken flag and the rest the target
    function automatic logic [32:0] predict(input logic [31:0] pc, input logic [31:0] inst);
        logic [31:0] next_pc;
        logic [31:0] offset;
        next_pc = pc + 32'd4;
        offset  = {{14{inst[15]}}, inst[15:0], 2'b00};
        case (inst[31:26])
            6'h02, 6'h03:               predict = {1'b1, next_pc[31:28], inst[25:0], 2'b00};
            6'h04, 6'h05, 6'h06, 6'h07: predict = inst[15] ? {1'b1, next_pc + offset} : 33'd0;
            default:                    predict = 33'd0;
        endcase
    endfunction

    always_comb begin
        exp_single = ref_delay || (ref_pc[3:2] == 2'd3);
        exp_inst0  = program_word(ref_pc);
        exp_inst1  = exp_single ? '0 : program_word(ref_pc + 32'd4);
        exp_pred0  = predict(ref_pc, exp_inst0);
        exp_pred1  = exp_single ? '0 : predict(ref_pc + 32'd4, exp_inst1);
    end

    assign accepted = bundle_valid && !stall;

    always @(posedge clk) begin
        if (rst) begin
            ref_pc      <= reset_pc;
            ref_delay   <= 1'b0;
            ref_target  <= '0;
            loop_passes <= 0;
            tail_hits   <= 0;
            entry_hits  <= 0;
            bundles     <= 0;
        end else if (redirect_valid) begin
            ref_pc    <= redirect_pc;
            ref_delay <= 1'b0;
        end else if (accepted) begin
            bundles <= bundles + 1;
            if (ref_pc == 32'h8000_0090) begin
                loop_passes <= loop_passes + 1;
            end
            if (ref_pc == 32'h8000_0110) begin
                tail_hits <= tail_hits + 1;
            end
            if (ref_pc == 32'h8000_0044) begin
                entry_hits <= entry_hits + 1;
            end
            if (ref_delay) begin
                ref_pc    <= ref_target;
                ref_delay <= 1'b0;
            end else if (exp_single) begin
                ref_pc     <= ref_pc + 32'd4;
                ref_delay  <= exp_pred0[32];
                ref_target <= exp_pred0[31:0];
            end else if (exp_pred1[32]) begin
                ref_pc     <= ref_pc + 32'd8;
                ref_delay  <= 1'b1;
                ref_target <= exp_pred1[31:0];
            end else if (exp_pred0[32]) begin
                ref_pc <= exp_pred0[31:0];
            end else begin
                ref_pc <= ref_pc + 32'd8;
            end
        end
    end

    // Words still owed by memory for the refill in flight
    always @(posedge clk) begin
        if (rst) begin
            refill_left    <= 0;
            last_word_seen <= 1'b0;
        end else begin
            last_word_seen <= mem_valid && refill_left == 1;
            if (mem_req) begin
                refill_left <= 4;
            end else if (mem_valid && refill_left != 0) begin
                refill_left <= refill_left - 1;
            end
        end
    end

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] expected);
        errors++;
        $display("error %0t: %s got %h expected %h", $time, what, got, expected);
    endtask

    // Checks sample at the falling edge, where inputs and outputs are settled
    pc_check: assert property (@(negedge clk) disable iff (rst)
        accepted |-> bundle_pc == ref_pc)
        else report_mismatch("bundle pc", bundle_pc, ref_pc);
    count_check: assert property (@(negedge clk) disable iff (rst)
        accepted |-> bundle_count == (exp_single ? 2'd1 : 2'd2))
        else report_mismatch("bundle count", 32'(bundle_count), exp_single ? 32'd1 : 32'd2);
    inst0_check: assert property (@(negedge clk) disable iff (rst)
        accepted |-> bundle_inst[0] == exp_inst0)
        else report_mismatch("slot 0 instruction", bundle_inst[0], exp_inst0);
    inst1_check: assert property (@(negedge clk) disable iff (rst)
        accepted |-> bundle_inst[1] == exp_inst1)
        else report_mismatch("slot 1 instruction", bundle_inst[1], exp_inst1);
    taken_check: assert property (@(negedge clk) disable iff (rst)
        accepted |-> bundle_pred_taken == {exp_pred1[32], exp_pred0[32]})
        else report_mismatch("taken flags", 32'(bundle_pred_taken),
                             32'({exp_pred1[32], exp_pred0[32]}));
    target0_check: assert property (@(negedge clk) disable iff (rst)
        accepted |-> bundle_pred_target[0] == exp_pred0[31:0])
        else report_mismatch("slot 0 target", bundle_pred_target[0], exp_pred0[31:0]);
    target1_check: assert property (@(negedge clk) disable iff (rst)
        accepted |-> bundle_pred_target[1] == exp_pred1[31:0])
        else report_mismatch("slot 1 target", bundle_pred_target[1], exp_pred1[31:0]);
    align_check: assert property (@(negedge clk) disable iff (rst)
        mem_req |-> mem_addr[3:0] == 4'd0)
        else report_mismatch("refill address", mem_addr, {mem_addr[31:4], 4'h0});
    stall_check: assert property (@(negedge clk) disable iff (rst)
        fetch_stall |-> !bundle_valid)
        else report_mismatch("bundle valid under fetch stall", 32'(bundle_valid), 32'd0);
    busy_check: assert property (@(negedge clk) disable iff (rst)
        (mem_req || refill_left != 0) |-> fetch_stall)
        else report_mismatch("fetch stall during refill", 32'(fetch_stall), 32'd1);
    overlap_check: assert property (@(negedge clk) disable iff (rst)
        (refill_left != 0) |-> !mem_req)
        else report_mismatch("refill request before the line is in", 32'(mem_req), 32'd0);
    resume_check: assert property (@(negedge clk) disable iff (rst)
        last_word_seen |-> !fetch_stall)
        else report_mismatch("fetch stall after the last refill word", 32'(fetch_stall),
                             32'd0);
    loop_check: assert property (@(negedge clk) disable iff (rst)
        (loop_passes >= 2 && !left_loop) |-> !mem_req)
        else report_mismatch("refill request in a cached loop", 32'(mem_req), 32'd0);

    task automatic next_cycle();
        @(posedge clk);
        #2;
        redirect_valid = 1'b0;
        stall          = hold_stall || ($urandom_range(3) == 0);
    endtask

    // Goal 0 is the third loop pass, goal 1 the bundle at 0x110, else the second visit to 0x44
    function automatic bit goal_reached(input int goal);
        case (goal)
            0:       goal_reached = loop_passes >= 3;
            1:       goal_reached = tail_hits >= 1;
            default: goal_reached = entry_hits >= 2;
        endcase
    endfunction

    task automatic run_until(input int goal, input string what, inout bit ok);
        int cycles;
        cycles = 0;
        while (ok && !goal_reached(goal) && cycles < 2000) begin
            next_cycle();
            cycles++;
        end
        if (ok && !goal_reached(goal)) begin
            $display("timeout while waiting for %s", what);
            ok = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(71));
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        stall          = 1'b0;
        hold_stall     = 1'b0;
        left_loop      = 1'b0;
        run_ok         = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        run_until(0, "three passes over the loop", run_ok);

        // Leave the loop with a redirect that arrives while stalled
        hold_stall = 1'b1;
        next_cycle();
        left_loop      = 1'b1;
        redirect_valid = 1'b1;
        redirect_pc    = 32'h8000_010c;
        repeat (3) next_cycle();
        hold_stall = 1'b0;
        run_until(1, "a bundle at 0x80000110", run_ok);

        redirect_valid = 1'b1;
        redirect_pc    = reset_pc;
        run_until(2, "a second bundle at 0x80000044", run_ok);

        $display("bundles accepted %0d, errors %0d", bundles, errors);
        if (run_ok && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
source/isa_pkg.sv
source/fetch_pkg.sv
source/fetch_cache_if.sv
source/branch_predictor.sv
source/icache.sv
source/fetch_unit.sv
source/fetch_top.sv
verif/imem_model.sv
verif/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fetch testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module fetch_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vfetch_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$log"; then
    exit 1
fi
exit 0
